//--- Makefile
# Verilator build and regression run for the ball tracker

VERILATOR ?= verilator
TOP       ?= tb_ball_tracker
FILELIST  ?= ball_tracker.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv testbench/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ball_tracker.f
+incdir+src
+incdir+testbench
src/pixel_pkg.sv
src/frame_pkg.sv
src/stream_framer.sv
src/rgb_to_hsv.sv
src/ball_classifier.sv
src/box_tracker.sv
src/frame_overlay.sv
src/ball_tracker_top.sv
testbench/tb_ball_tracker.sv

//--- src/ball_classifier.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// per colour threshold match plus run filter on accepted beats
////////////////////////////////////////////////////////////
`include "vision_params.svh"

module ball_classifier (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   advance,
	input  frame_pkg::beat_t       beat_in,
	input  pixel_pkg::hsv_t        hsv,
	input  logic                   valid_in,
	output frame_pkg::beat_t       beat_out,
	output pixel_pkg::ball_flags_t raw,
	output pixel_pkg::ball_flags_t confirmed,
	output logic                   valid_out
);
	localparam int CNT_W = $clog2(`RUN_LENGTH + 1);

	logic [CNT_W-1:0]       run_cnt [4];    // matching beats so far, saturates
	logic [CNT_W-1:0]       run_next [4];
	pixel_pkg::ball_flags_t raw_next;
	pixel_pkg::ball_flags_t conf_next;

	always_comb begin
		raw_next[`IDX_RED]    = `IS_RED(hsv.hue, hsv.sat, hsv.val);
		raw_next[`IDX_ORANGE] = `IS_ORANGE(hsv.hue, hsv.sat, hsv.val);
		raw_next[`IDX_TEAL]   = `IS_TEAL(hsv.hue, hsv.sat, hsv.val);
		raw_next[`IDX_PINK]   = `IS_PINK(hsv.hue, hsv.sat, hsv.val);

		for (int i = 0; i < 4; i++) begin
			if (beat_in.sop || !raw_next[i]) begin   // descriptor or miss breaks the run
				run_next[i] = '0;
			end else if (run_cnt[i] == CNT_W'(`RUN_LENGTH)) begin
				run_next[i] = run_cnt[i];            // hold at the limit
			end else begin
				run_next[i] = run_cnt[i] + 1'b1;
			end
			conf_next[i] = (run_next[i] == CNT_W'(`RUN_LENGTH));   // this beat included
		end
	end

	////////////////////////////////////////////////////////////
	// run counters, step only on beats the pipeline accepts
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
			for (int i = 0; i < 4; i++) begin
				run_cnt[i] <= '0;
			end
		end else if (advance) begin
			valid_out <= valid_in;
			if (valid_in) begin
				for (int i = 0; i < 4; i++) begin
					run_cnt[i] <= run_next[i];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			beat_out  <= beat_in;
			raw       <= raw_next;
			confirmed <= conf_next;
		end
	end

endmodule

//--- src/ball_tracker_top.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// ball detector top: framer, hsv, classifier, box tracker and
// overlay chained on one valid/ready stream
////////////////////////////////////////////////////////////

module ball_tracker_top (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                mode,          // 1 = overlay picture
	input  pixel_pkg::rgb_t     sink_data,
	input  logic                sink_valid,
	input  logic                sink_sop,
	input  logic                sink_eop,
	output logic                sink_ready,
	output pixel_pkg::rgb_t     source_data,
	output logic                source_valid,
	output logic                source_sop,
	output logic                source_eop,
	input  logic                source_ready,
	output frame_pkg::box_set_t boxes,
	output logic                frame_done
);
	logic                   advance;       // global pipeline enable
	frame_pkg::beat_t       fr_beat;
	logic                   fr_valid;
	frame_pkg::beat_t       hsv_beat;
	pixel_pkg::hsv_t        hsv;
	logic                   hsv_valid;
	frame_pkg::beat_t       cls_beat;
	pixel_pkg::ball_flags_t conf_flags;
	logic                   cls_valid;

	assign sink_ready = advance;

	stream_framer i_framer (
		.clk        (clk),
		.reset_n    (reset_n),
		.sink_data  (sink_data),
		.sink_valid (sink_valid),
		.sink_sop   (sink_sop),
		.sink_eop   (sink_eop),
		.advance    (advance),
		.beat       (fr_beat),
		.beat_valid (fr_valid)
	);

	rgb_to_hsv i_hsv (
		.clk       (clk),
		.reset_n   (reset_n),
		.advance   (advance),
		.beat_in   (fr_beat),
		.valid_in  (fr_valid),
		.beat_out  (hsv_beat),
		.hsv       (hsv),
		.valid_out (hsv_valid)
	);

	ball_classifier i_classifier (
		.clk       (clk),
		.reset_n   (reset_n),
		.advance   (advance),
		.beat_in   (hsv_beat),
		.hsv       (hsv),
		.valid_in  (hsv_valid),
		.beat_out  (cls_beat),
		.raw       (),              // unfiltered flags, debug tap only
		.confirmed (conf_flags),
		.valid_out (cls_valid)
	);

	// tracker sees each classifier beat once, on the edge it moves on
	box_tracker i_boxes (
		.clk        (clk),
		.reset_n    (reset_n),
		.beat       (cls_beat),
		.confirmed  (conf_flags),
		.valid      (cls_valid && advance),
		.boxes      (boxes),
		.frame_done (frame_done)
	);

	frame_overlay i_overlay (
		.clk          (clk),
		.reset_n      (reset_n),
		.mode         (mode),
		.beat_in      (cls_beat),
		.confirmed    (conf_flags),
		.valid_in     (cls_valid),
		.boxes        (boxes),
		.source_ready (source_ready),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.advance      (advance)
	);

endmodule

//--- src/box_tracker.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// leftmost and rightmost confirmed x per colour below the row
// limit, reported with a one cycle strobe at each video eop
////////////////////////////////////////////////////////////
`include "vision_params.svh"

module box_tracker (
	input  logic                   clk,
	input  logic                   reset_n,
	input  frame_pkg::beat_t       beat,
	input  pixel_pkg::ball_flags_t confirmed,
	input  logic                   valid,      // beat moves on this edge
	output frame_pkg::box_set_t    boxes,
	output logic                   frame_done
);
	localparam frame_pkg::box_t EMPTY_BOX = '{
		left:  frame_pkg::coord_t'(`IMAGE_W - 1),
		right: frame_pkg::coord_t'(0)
	};

	frame_pkg::box_set_t work;       // bounds of the frame in progress
	frame_pkg::box_set_t work_next;  // same, including the current beat
	logic                in_roi;

	always_comb begin
		in_roi    = (beat.y > frame_pkg::coord_t'(`ROI_Y_MIN));   // near field only
		work_next = work;
		for (int i = 0; i < 4; i++) begin
			if (valid && confirmed[i] && in_roi) begin
				if (beat.x < work[i].left)
					work_next[i].left = beat.x;
				if (beat.x > work[i].right)
					work_next[i].right = beat.x;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			work       <= {4{EMPTY_BOX}};
			boxes      <= {4{EMPTY_BOX}};
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (valid && beat.sop)
				work <= {4{EMPTY_BOX}};   // restart for the new packet
			else
				work <= work_next;

			// control packets never end a frame
			if (valid && beat.eop && beat.video) begin
				boxes      <= work_next;   // last pixel counts too
				frame_done <= 1'b1;
			end
		end
	end

	// one strobe per frame, the eop beat moves on once
	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		frame_done |=> !frame_done);

endmodule

//--- src/frame_overlay.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// output stage: highlight or grey picture with the box edges of
// the previous frame, mode select, and the source register
////////////////////////////////////////////////////////////
`include "vision_params.svh"

module frame_overlay (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   mode,
	input  frame_pkg::beat_t       beat_in,
	input  pixel_pkg::ball_flags_t confirmed,
	input  logic                   valid_in,
	input  frame_pkg::box_set_t    boxes,
	input  logic                   source_ready,
	output pixel_pkg::rgb_t        source_data,
	output logic                   source_valid,
	output logic                   source_sop,
	output logic                   source_eop,
	output logic                   advance
);
	// indexed like the flags: red, orange, teal, pink
	localparam pixel_pkg::rgb_t EDGE_COL [4] = '{
		`EDGE_RED, `EDGE_ORANGE, `EDGE_TEAL, `EDGE_PINK
	};
	localparam frame_pkg::coord_t EMPTY_LEFT = frame_pkg::coord_t'(`IMAGE_W - 1);

	pixel_pkg::channel_t grey;
	pixel_pkg::rgb_t     highlight;
	pixel_pkg::rgb_t     drawn;
	pixel_pkg::rgb_t     out_pix;

	always_comb begin
		// green/2 + red/4 + blue/4, at most 253 so no overflow
		grey = beat_in.pixel.green[7:1] + beat_in.pixel.red[7:2] + beat_in.pixel.blue[7:2];

		if (confirmed[`IDX_RED])
			highlight = `HL_RED;
		else if (confirmed[`IDX_TEAL])
			highlight = `HL_TEAL;
		else if (confirmed[`IDX_ORANGE])
			highlight = `HL_ORANGE;
		else if (confirmed[`IDX_PINK])
			highlight = `HL_PINK;
		else
			highlight = '{red: grey, green: grey, blue: grey};

		drawn = highlight;
		for (int i = 0; i < 4; i++) begin   // later colour paints over, pink ends on top
			if (boxes[i].left != EMPTY_LEFT && boxes[i].right != '0 &&
				(beat_in.x == boxes[i].left || beat_in.x == boxes[i].right)) begin
				drawn = EDGE_COL[i];
			end
		end

		// descriptor word and control packets pass untouched
		out_pix = (mode && !beat_in.sop && beat_in.video) ? drawn : beat_in.pixel;
	end

	////////////////////////////////////////////////////////////
	// source register, the whole pipeline waits while it is full
	assign advance = !source_valid || source_ready;

	always_ff @(posedge clk) begin
		if (!reset_n)
			source_valid <= 1'b0;
		else if (advance)
			source_valid <= valid_in;
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			source_data <= out_pix;
			source_sop  <= beat_in.sop;
			source_eop  <= beat_in.eop;
		end
	end

	// a stalled word is held until the sink takes it
	a_hold_stall: assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && !source_ready |=> source_valid && $stable(source_data));

endmodule

//--- src/frame_pkg.sv
////////////////////////////////////////////////////////////
// frame side types: pixel position, pipeline beat, ball boxes
////////////////////////////////////////////////////////////
package frame_pkg;

	// covers 0..2047, enough for both image axes
	typedef logic [10:0] coord_t;

	// one stream word plus what the pipeline learned about it
	typedef struct packed {
		pixel_pkg::rgb_t pixel;
		logic            sop;
		logic            eop;
		logic            video;   // packet carries image data
		coord_t          x;
		coord_t          y;
	} beat_t;

	// horizontal extent of one ball
	// empty when left is the last column or right is column 0
	typedef struct packed {
		coord_t left;
		coord_t right;
	} box_t;

	// index follows the flag order: red, orange, teal, pink
	typedef box_t [3:0] box_set_t;

endpackage

//--- src/pixel_pkg.sv
////////////////////////////////////////////////////////////
// colour side types: channels, rgb and hsv pixels, ball flags
////////////////////////////////////////////////////////////
package pixel_pkg;

	// one 8 bit colour or hsv component
	typedef logic [7:0] channel_t;

	// video pixel as it travels on the stream
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} rgb_t;

	// hue is halved to fit 0..180 into a byte
	typedef struct packed {
		channel_t hue;
		channel_t sat;      // 0..255
		channel_t val;      // max channel
	} hsv_t;

	// one flag per ball colour
	// bit 0 red, 1 orange, 2 teal, 3 pink
	typedef logic [3:0] ball_flags_t;

endpackage

//--- src/rgb_to_hsv.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// registered rgb to hsv conversion, hue halved to 0..180
////////////////////////////////////////////////////////////

module rgb_to_hsv (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             advance,
	input  frame_pkg::beat_t beat_in,
	input  logic             valid_in,
	output frame_pkg::beat_t beat_out,
	output pixel_pkg::hsv_t  hsv,
	output logic             valid_out
);
	pixel_pkg::channel_t r, g, b;
	pixel_pkg::channel_t v_max, v_min, delta;
	logic [17:0]         hue_num;    // up to 360 * 255
	logic [17:0]         hue_div;
	logic [8:0]          hue_full;   // 0..360
	logic [15:0]         sat_num;
	logic [7:0]          sat_div;

	always_comb begin
		r = beat_in.pixel.red;
		g = beat_in.pixel.green;
		b = beat_in.pixel.blue;
		v_max = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
		v_min = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);
		delta = v_max - v_min;

		// sector numerators, the total never goes negative so wrap in between is harmless
		if (v_max == r) begin
			if (b > g)
				hue_num = 18'd360 * delta + 18'd60 * g - 18'd60 * b;   // wraps past 360
			else
				hue_num = 18'd60 * (g - b);
		end else if (v_max == g) begin
			hue_num = 18'd120 * delta + 18'd60 * b - 18'd60 * r;
		end else begin
			hue_num = 18'd240 * delta + 18'd60 * r - 18'd60 * g;
		end
		hue_div  = (delta == 8'd0) ? 18'd1 : {10'd0, delta};     // grey pixel, no sector
		hue_full = (delta == 8'd0) ? 9'd0 : 9'(hue_num / hue_div);

		sat_num = 16'd255 * delta;
		sat_div = (v_max == 8'd0) ? 8'd1 : v_max;   // black gives delta 0, so sat 0
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			valid_out <= 1'b0;
		else if (advance)
			valid_out <= valid_in;
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			beat_out <= beat_in;
			hsv.hue  <= hue_full[8:1];
			hsv.sat  <= 8'(sat_num / {8'd0, sat_div});
			hsv.val  <= v_max;
		end
	end

	// halved hue tops out at 180 whatever the sector
	a_hue_range: assert property (@(posedge clk) disable iff (!reset_n)
		valid_out |-> hsv.hue <= 8'd180);

endmodule

//--- src/stream_framer.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// input stage: registers sink beats, numbers the pixels and
// tags video packets from the nibble in their sop word
////////////////////////////////////////////////////////////
`include "vision_params.svh"

module stream_framer (
	input  logic             clk,
	input  logic             reset_n,
	input  pixel_pkg::rgb_t  sink_data,
	input  logic             sink_valid,
	input  logic             sink_sop,
	input  logic             sink_eop,
	input  logic             advance,
	output frame_pkg::beat_t beat,
	output logic             beat_valid
);
	frame_pkg::coord_t x_next;   // position of the next pixel beat
	frame_pkg::coord_t y_next;
	logic              video_q;  // tag of the packet in flight
	logic              sop_video;

	assign sop_video = (sink_data.blue[3:0] == 4'h0);   // non-zero nibble = control packet

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			beat_valid <= 1'b0;
			x_next     <= '0;
			y_next     <= '0;
			video_q    <= 1'b0;
		end else if (advance) begin
			beat_valid <= sink_valid;
			if (sink_valid && sink_sop) begin   // new packet, first pixel lands on 0,0
				x_next  <= '0;
				y_next  <= '0;
				video_q <= sop_video;
			end else if (sink_valid) begin
				if (x_next == frame_pkg::coord_t'(`IMAGE_W - 1)) begin   // end of line
					x_next <= '0;
					y_next <= y_next + 1'b1;
				end else begin
					x_next <= x_next + 1'b1;
				end
			end
		end
	end

	// payload, only looked at while beat_valid is set
	always_ff @(posedge clk) begin
		if (advance) begin
			beat.pixel <= sink_data;
			beat.sop   <= sink_sop;
			beat.eop   <= sink_eop;
			beat.video <= sink_sop ? sop_video : video_q;
			beat.x     <= sink_sop ? '0 : x_next;
			beat.y     <= sink_sop ? '0 : y_next;
		end
	end

	// counters wrap on the line width, so x never leaves the image
	a_pos_in_frame: assert property (@(posedge clk) disable iff (!reset_n)
		beat_valid |-> beat.x < `IMAGE_W && (!beat.video || beat.y < `IMAGE_H));

endmodule

//--- src/vision_params.svh
////////////////////////////////////////////////////////////
// frame geometry, run filter, colour rules and overlay colours
// shared by the detector pipeline stages, pulled in with `include
////////////////////////////////////////////////////////////
`ifndef VISION_PARAMS_SVH
`define VISION_PARAMS_SVH

`define IMAGE_W     640     // pixels per line
`define IMAGE_H     480     // lines per frame
`define ROI_Y_MIN   280     // boxes only track rows below this one
`define RUN_LENGTH  4       // accepted pixels in a row to confirm a colour

// flag bit positions, also the box index of each colour
`define IDX_RED     0
`define IDX_ORANGE  1
`define IDX_TEAL    2
`define IDX_PINK    3

// colour rules on hue (0..180), saturation and value
`define IS_RED(h, s, v) ( \
	((((h) >= 150 && (h) <= 180) || (h) <= 6) && (s) > 84 && (v) > 245) || \
	((h) <= 6 && (((v) > 229 && (s) > 17 && (s) < 155) || \
		((v) > 210 && (s) > 130))) || \
	((h) >= 160 && (h) <= 180 && (((s) >= 76 && (v) >= 249) || \
		((s) >= 102 && (v) >= 140))) || \
	((((h) >= 160 && (h) <= 180) || (h) <= 4) && (s) > 140 && (s) <= 179 && \
		(v) >= 89 && (v) <= 106) || \
	((((h) >= 172 && (h) <= 180) || (h) <= 6) && \
		(((v) > 105 && (s) > 102) || ((s) > 82 && (v) > 168))))
`define IS_ORANGE(h, s, v) ( \
	((h) >= 16 && (h) <= 25 && (s) > 133 && (v) > 124) || \
	((h) >= 23 && (h) <= 30 && (((v) > 155 && (s) > 127) || \
		((s) >= 153 && (v) > 252) || ((v) > 100 && (s) > 247))))
`define IS_TEAL(h, s, v) ( \
	((h) >= 60 && (h) <= 85 && (s) > 100 && (s) < 200 && (v) > 110 && (v) < 245) || \
	((h) >= 53 && (h) <= 80 && (s) > 80 && (s) < 114 && (v) > 60))
`define IS_PINK(h, s, v) ( \
	((h) >= 175 || (h) <= 22) && (s) > 83 && (s) < 190 && (v) > 205)

// highlight fill for confirmed pixels
`define HL_RED      24'hff1000
`define HL_ORANGE   24'hea9e1b
`define HL_TEAL     24'h04bd42
`define HL_PINK     24'hdf55e2

// box edge colours
`define EDGE_RED    24'hff0000
`define EDGE_ORANGE 24'hffa500
`define EDGE_TEAL   24'h008080
`define EDGE_PINK   24'hffc0cb

`endif

//--- testbench/tb_ball_tracker_tasks.svh
////////////////////////////////////////////////////////////
// reference model, drive and compare tasks and the directed tests
////////////////////////////////////////////////////////////
`ifndef TB_BALL_TRACKER_TASKS_SVH
`define TB_BALL_TRACKER_TASKS_SVH

localparam frame_pkg::box_t NO_BOX = '{left: frame_pkg::coord_t'(`IMAGE_W - 1), right: '0};
// red, orange, teal, pink, grey
localparam pixel_pkg::rgb_t SAMPLE [5] = '{
	24'hff1000, 24'hea9e1b, 24'h3cb478, 24'hffb496, 24'h646464
};
localparam int RED_X0  = 100;   // red run in test 3
localparam int RED_LEN = 20;

int                  run_cnt [4];
frame_pkg::coord_t   pos_x, pos_y;
logic                pkt_video;
logic                model_mode;
frame_pkg::box_set_t work_boxes, model_boxes;

function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
endfunction

function automatic void model_reset();
	for (int i = 0; i < 4; i++) begin
		run_cnt[i]     = 0;
		work_boxes[i]  = NO_BOX;
		model_boxes[i] = NO_BOX;
	end
	pos_x      = '0;
	pos_y      = '0;
	pkt_video  = 1'b0;
	model_mode = 1'b0;
endfunction

function automatic pixel_pkg::hsv_t model_hsv(pixel_pkg::rgb_t p);
	int r, g, b, mx, mn, d, h;
	pixel_pkg::hsv_t res;
	r = p.red;
	g = p.green;
	b = p.blue;
	mx = (r > g) ? r : g;
	mx = (b > mx) ? b : mx;
	mn = (r < g) ? r : g;
	mn = (b < mn) ? b : mn;
	d  = mx - mn;
	if (d == 0) h = 0;                                  // grey, no sector
	else if (mx == r && b > g) h = (360 * d + 60 * (g - b)) / d;
	else if (mx == r) h = 60 * (g - b) / d;
	else if (mx == g) h = (120 * d + 60 * (b - r)) / d;
	else h = (240 * d + 60 * (r - g)) / d;
	res.hue = pixel_pkg::channel_t'(h / 2);
	res.sat = (mx == 0) ? 8'd0 : pixel_pkg::channel_t'(255 * d / mx);
	res.val = pixel_pkg::channel_t'(mx);
	return res;
endfunction

function automatic pixel_pkg::ball_flags_t model_classify(pixel_pkg::hsv_t c);
	int h, s, v;
	pixel_pkg::ball_flags_t f;
	h = c.hue;
	s = c.sat;
	v = c.val;
	f[0] = ((h >= 150 || h <= 6) && s > 84 && v > 245)
		|| (h <= 6 && ((v > 229 && s > 17 && s < 155) || (v > 210 && s > 130)))
		|| (h >= 160 && ((s >= 76 && v >= 249) || (s >= 102 && v >= 140)))
		|| ((h >= 160 || h <= 4) && s > 140 && s <= 179 && v >= 89 && v <= 106)
		|| ((h >= 172 || h <= 6) && ((v > 105 && s > 102) || (s > 82 && v > 168)));
	f[1] = (h >= 16 && h <= 25 && s > 133 && v > 124)
		|| (h >= 23 && h <= 30 && ((v > 155 && s > 127) || (s >= 153 && v > 252)
			|| (v > 100 && s > 247)));
	f[2] = (h >= 60 && h <= 85 && s > 100 && s < 200 && v > 110 && v < 245)
		|| (h >= 53 && h <= 80 && s > 80 && s < 114 && v > 60);
	f[3] = (h >= 175 || h <= 22) && s > 83 && s < 190 && v > 205;
	return f;
endfunction

function automatic logic on_edge(frame_pkg::box_t bx, frame_pkg::coord_t x);
	if (bx.left == frame_pkg::coord_t'(`IMAGE_W - 1) || bx.right == '0)
		return 1'b0;   // empty box draws nothing
	return (x == bx.left || x == bx.right);
endfunction

// one beat through position, hsv, filter, overlay and tracker rules
function automatic void model_beat(pixel_pkg::rgb_t pix, logic sop, logic eop);
	frame_pkg::coord_t      x, y;
	pixel_pkg::ball_flags_t raw, conf;
	pixel_pkg::rgb_t        drawn;
	pixel_pkg::channel_t    grey;
	out_beat_t              ob;
	if (sop) begin
		pkt_video = (pix.blue[3:0] == 4'h0);
		x = '0;
		y = '0;
		pos_x = '0;
		pos_y = '0;
	end else begin
		x = pos_x;
		y = pos_y;
		if (pos_x == frame_pkg::coord_t'(`IMAGE_W - 1)) begin
			pos_x = '0;
			pos_y = pos_y + 1'b1;
		end else begin
			pos_x = pos_x + 1'b1;
		end
	end
	raw = model_classify(model_hsv(pix));
	for (int i = 0; i < 4; i++) begin
		if (sop || !raw[i]) run_cnt[i] = 0;
		else if (run_cnt[i] < `RUN_LENGTH) run_cnt[i]++;
		conf[i] = (run_cnt[i] == `RUN_LENGTH);
	end
	grey = pixel_pkg::channel_t'(pix.green / 2 + pix.red / 4 + pix.blue / 4);
	if (conf[0]) drawn = `HL_RED;
	else if (conf[2]) drawn = `HL_TEAL;
	else if (conf[1]) drawn = `HL_ORANGE;
	else if (conf[3]) drawn = `HL_PINK;
	else drawn = {grey, grey, grey};
	if (on_edge(model_boxes[3], x)) drawn = `EDGE_PINK;
	else if (on_edge(model_boxes[2], x)) drawn = `EDGE_TEAL;
	else if (on_edge(model_boxes[1], x)) drawn = `EDGE_ORANGE;
	else if (on_edge(model_boxes[0], x)) drawn = `EDGE_RED;
	ob.data = (model_mode && !sop && pkt_video) ? drawn : pix;
	ob.sop  = sop;
	ob.eop  = eop;
	exp_q.push_back(ob);
	// tracker, boxes of this frame only show up from the next beat on
	for (int i = 0; i < 4; i++) begin
		if (sop) work_boxes[i] = NO_BOX;
		else if (conf[i] && y > frame_pkg::coord_t'(`ROI_Y_MIN)) begin
			if (x < work_boxes[i].left) work_boxes[i].left = x;
			if (x > work_boxes[i].right) work_boxes[i].right = x;
		end
	end
	if (eop && pkt_video)
		model_boxes = work_boxes;
endfunction

////////////////////////////////////////////////////////////
task automatic compare_rgb(string name, pixel_pkg::rgb_t exp, pixel_pkg::rgb_t act);
	if (exp !== act)
		stop_with_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
endtask

task automatic compare_box(string name, frame_pkg::box_t exp, frame_pkg::box_t act);
	if (exp !== act)
		stop_with_error($sformatf("mismatch %s: expected %0d..%0d, actual %0d..%0d",
			name, exp.left, exp.right, act.left, act.right));
endtask

task automatic compare_flag(string name, logic exp, logic act);
	if (exp !== act)
		stop_with_error($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
endtask

// every drive task starts and ends on a rising edge
task automatic send_beat(pixel_pkg::rgb_t pix, logic sop, logic eop);
	model_beat(pix, sop, eop);
	sink_data  <= pix;
	sink_valid <= 1'b1;
	sink_sop   <= sop;
	sink_eop   <= eop;
	do @(posedge clk); while (!sink_ready);   // taken on this edge
endtask

task automatic send_packet(pixel_pkg::rgb_t sop_word);
	send_beat(sop_word, 1'b1, pkt_q.size() == 0);
	for (int i = 0; i < pkt_q.size(); i++)
		send_beat(pkt_q[i], 1'b0, i == pkt_q.size() - 1);
	pkt_q.delete();
	sink_valid <= 1'b0;
	sink_sop   <= 1'b0;
	sink_eop   <= 1'b0;
	@(posedge clk);
endtask

task automatic set_mode(logic m);
	model_mode = m;
	mode <= m;
	@(posedge clk);
endtask

task automatic wait_drain();
	while (exp_q.size() != 0) @(posedge clk);
	repeat (4) @(posedge clk);
endtask

////////////////////////////////////////////////////////////
task automatic test_passthrough();
	test_name = "passthrough";
	set_mode(1'b0);
	for (int i = 0; i < BEATS_T1 - 1; i++)
		pkt_q.push_back(SAMPLE[i % 5] ^ pixel_pkg::rgb_t'(i));
	send_packet(24'h123450);
	wait_drain();
endtask

task automatic test_highlight();
	test_name = "highlight";
	set_mode(1'b1);
	for (int s = 0; s < 5; s++) begin
		repeat (6) pkt_q.push_back(SAMPLE[s]);   // long enough to confirm
		repeat (2) pkt_q.push_back(SAMPLE[4]);
		repeat (3) pkt_q.push_back(SAMPLE[s]);   // too short
		repeat (2) pkt_q.push_back(SAMPLE[4]);
	end
	send_packet(24'h000000);
	wait_drain();
endtask

task automatic test_box_report();
	frame_pkg::box_t red_box;
	test_name = "box report";
	for (int i = 0; i < FRAME_ROWS * `IMAGE_W; i++) begin
		if (i >= (FRAME_ROWS - 1) * `IMAGE_W + RED_X0 &&
			i < (FRAME_ROWS - 1) * `IMAGE_W + RED_X0 + RED_LEN)
			pkt_q.push_back(SAMPLE[0]);
		else
			pkt_q.push_back(SAMPLE[4]);
	end
	send_packet(24'h000000);
	do @(posedge clk); while (!frame_done);
	red_box.left  = frame_pkg::coord_t'(RED_X0 + `RUN_LENGTH - 1);   // first confirmed pixel
	red_box.right = frame_pkg::coord_t'(RED_X0 + RED_LEN - 1);
	compare_box("box report red", red_box, boxes[0]);
	for (int i = 1; i < 4; i++)
		compare_box("box report absent colour", NO_BOX, boxes[i]);
	wait_drain();
endtask

task automatic test_box_edges();
	test_name = "box edges";
	edge_seen = 0;
	repeat (`IMAGE_W) pkt_q.push_back(SAMPLE[4]);
	send_packet(24'h000000);
	wait_drain();
	if (edge_seen != 2)
		stop_with_error($sformatf("mismatch %s: expected 2 red edge pixels, actual %0d",
			test_name, edge_seen));
endtask

task automatic test_backpressure();
	test_name = "backpressure";
	random_ready <= 1'b1;
	for (int i = 0; i < 300; i++)
		pkt_q.push_back(SAMPLE[(i / 7) % 5]);
	send_packet(24'h4020a0);
	repeat (12) pkt_q.push_back(SAMPLE[0]);   // control packet, stays raw
	send_packet(24'h000005);
	wait_drain();
	random_ready <= 1'b0;
endtask

`endif

//--- testbench/tb_ball_tracker.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// testbench for the ball detector, directed tests against a
// reference model with random back-pressure on the source
////////////////////////////////////////////////////////////
`include "vision_params.svh"

module tb_ball_tracker;
	localparam int CLK_PERIOD = 100;
	localparam int FRAME_ROWS = `ROI_Y_MIN + 2;          // last row sits inside the roi
	localparam int BEATS_T1   = 21;
	localparam int BEATS_T2   = 1 + 5 * 13;
	localparam int BEATS_T3   = 1 + FRAME_ROWS * `IMAGE_W;
	localparam int BEATS_T4   = 1 + `IMAGE_W;
	localparam int BEATS_T5   = 1 + 300 + 1 + 12;
	localparam longint TOTAL_BEATS = BEATS_T1 + BEATS_T2 + BEATS_T3 + BEATS_T4 + BEATS_T5;
	localparam longint WATCHDOG_NS = (TOTAL_BEATS * 4 + 2000) * CLK_PERIOD;   // 4x stall margin

	typedef struct packed {
		pixel_pkg::rgb_t data;
		logic            sop;
		logic            eop;
	} out_beat_t;

	logic                clk;
	logic                reset_n;
	logic                mode;
	pixel_pkg::rgb_t     sink_data;
	logic                sink_valid;
	logic                sink_sop;
	logic                sink_eop;
	logic                sink_ready;
	pixel_pkg::rgb_t     source_data;
	logic                source_valid;
	logic                source_sop;
	logic                source_eop;
	logic                source_ready;
	frame_pkg::box_set_t boxes;
	logic                frame_done;

	out_beat_t       exp_q[$];       // expected source beats in order
	pixel_pkg::rgb_t pkt_q[$];       // pixels of the packet being built
	logic [31:0]     lfsr_state = 32'hd1b6ef95;
	logic            random_ready;   // back-pressure on
	logic            gap_bit;
	string           test_name = "reset";
	int              edge_seen;      // red box edge words seen on the source

	// any failure lands here
	task automatic stop_with_error(string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	`include "tb_ball_tracker_tasks.svh"

	ball_tracker_top i_dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.mode         (mode),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.sink_ready   (sink_ready),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.source_ready (source_ready),
		.boxes        (boxes),
		.frame_done   (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_error("watchdog expired, the DUT stopped moving beats");
	end

	////////////////////////////////////////////////////////////
	// source ready, two lfsr bits per cycle, low only when both are 0
	always @(posedge clk) begin
		if (random_ready) begin
			lfsr_state = lfsr_next(lfsr_state);
			gap_bit    = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
			source_ready <= gap_bit | lfsr_state[0];
		end else begin
			source_ready <= 1'b1;
		end
	end

	// output monitor, values read here are the ones handed over on this edge
	always @(posedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			if (exp_q.size() == 0)
				stop_with_error($sformatf("%s: source beat with nothing expected", test_name));
			compare_rgb(test_name, exp_q[0].data, source_data);
			compare_flag({test_name, " sop"}, exp_q[0].sop, source_sop);
			compare_flag({test_name, " eop"}, exp_q[0].eop, source_eop);
			void'(exp_q.pop_front());
			if (source_data == pixel_pkg::rgb_t'(`EDGE_RED))
				edge_seen++;
		end
	end

	initial begin
		mode         = 1'b0;
		sink_data    = '0;
		sink_valid   = 1'b0;
		sink_sop     = 1'b0;
		sink_eop     = 1'b0;
		source_ready = 1'b1;
		random_ready = 1'b0;
		reset_n      = 1'b0;
		model_reset();
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < 4; i++)
			compare_box("reset boxes", NO_BOX, boxes[i]);
		compare_flag("reset source_valid", 1'b0, source_valid);
		compare_flag("reset frame_done", 1'b0, frame_done);

		test_passthrough();
		test_highlight();
		test_box_report();
		test_box_edges();
		test_backpressure();

		$display("Regression passed");
		$finish;
	end

endmodule
